//--- hw/biquad_pkg.sv
// Biquad filter shared types
package biquad_pkg;

    // Q2.14 coefficients, 14 fraction bits
    localparam int COEF_FRAC = 14;

    typedef logic signed [15:0] sample_t;   // Audio sample and history word
    typedef logic signed [15:0] coef_t;     // Q2.14, 16384 is 1.0
    typedef logic signed [35:0] acc_t;      // Five full-scale products fit

    // Coefficient select for bank writes
    typedef enum logic [2:0] {
        B0 = 3'd0,
        B1 = 3'd1,
        B2 = 3'd2,
        A1 = 3'd3,
        A2 = 3'd4
    } coef_sel_e;

    // Full active set, bank to sequencer
    typedef struct packed {
        coef_t b0;
        coef_t b1;
        coef_t b2;
        coef_t a1;
        coef_t a2;
    } coef_set_t;

    // One shadow register write
    typedef struct packed {
        coef_sel_e sel;
        coef_t     value;
    } coef_wr_t;

endpackage

//--- hw/mac_accum.sv
// Shared multiply-accumulate unit
`timescale 1ns/1ps

module mac_accum #(
    parameter int ACC_W = 36
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    enable,
    input  biquad_pkg::coef_t       a_in,
    input  biquad_pkg::sample_t     b_in,
    input  logic                    negate,
    output logic signed [ACC_W-1:0] acc
);

    logic signed [31:0]      product;
    logic signed [ACC_W-1:0] product_ext;
    logic signed [ACC_W-1:0] term;
    logic signed [ACC_W-1:0] base;

    // Full 16x16 signed product
    assign product = a_in * b_in;

    // Sign extension to accumulator width
    assign product_ext = product;

    // Feedback taps subtract
    assign term = negate ? -product_ext : product_ext;

    // First tap of a sample starts from zero
    assign base = clear ? '0 : acc;

    always_ff @(posedge clk) begin
        if (!reset) begin
            acc <= '0;
        end else if (enable) begin
            acc <= base + term;   // One cycle operands to result
        end
    end

    // Sequencer only clears on an enabled tap
    a_clear_needs_enable: assert property (
        @(posedge clk) disable iff (!reset)
        clear |-> enable
    ) else $error("mac_accum: clear without enable");

endmodule

//--- hw/coef_bank.sv
// Coefficient shadow bank
`timescale 1ns/1ps

module coef_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  coef_wr_en,
    input  biquad_pkg::coef_wr_t  coef_wr,
    input  logic                  coef_commit,
    input  logic                  sample_start,
    output biquad_pkg::coef_set_t coefs
);

    // Passthrough set, b0 at unity
    localparam biquad_pkg::coef_t     COEF_ONE     = 16'sd16384;
    localparam biquad_pkg::coef_set_t COEF_DEFAULT = '{
        b0: COEF_ONE,
        b1: '0,
        b2: '0,
        a1: '0,
        a2: '0
    };

    biquad_pkg::coef_set_t shadow;
    biquad_pkg::coef_set_t active;
    logic                  pending;   // Commit waiting for a sample boundary
    logic                  swap;

    assign swap  = sample_start && pending;
    assign coefs = active;

    always_ff @(posedge clk) begin
        if (!reset) begin
            shadow <= COEF_DEFAULT;
        end else if (coef_wr_en) begin
            case (coef_wr.sel)
                biquad_pkg::B0: shadow.b0 <= coef_wr.value;
                biquad_pkg::B1: shadow.b1 <= coef_wr.value;
                biquad_pkg::B2: shadow.b2 <= coef_wr.value;
                biquad_pkg::A1: shadow.a1 <= coef_wr.value;
                biquad_pkg::A2: shadow.a2 <= coef_wr.value;
                default: ;
            endcase
        end
    end

    // Swap lands on the accepting edge, so that sample sees the new set
    always_ff @(posedge clk) begin
        if (!reset) begin
            active <= COEF_DEFAULT;
        end else if (swap) begin
            active <= shadow;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            pending <= 1'b0;
        end else if (coef_commit) begin
            pending <= 1'b1;   // A fresh commit re-arms
        end else if (swap) begin
            pending <= 1'b0;
        end
    end

    a_wr_sel_legal: assert property (
        @(posedge clk) disable iff (!reset)
        coef_wr_en |-> coef_wr.sel inside {biquad_pkg::B0, biquad_pkg::B1, biquad_pkg::B2,
                                           biquad_pkg::A1, biquad_pkg::A2}
    ) else $error("coef_bank: write to illegal coefficient select");

endmodule

//--- hw/biquad_sequencer.sv
// Biquad tap sequencer
`timescale 1ns/1ps

module biquad_sequencer #(
    parameter int ACC_W = 36
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  biquad_pkg::sample_t   in_sample,
    output logic                  out_valid,
    input  logic                  out_ready,
    output biquad_pkg::sample_t   out_sample,
    input  biquad_pkg::coef_set_t coefs,
    output logic                  sample_start
);

    // Rounding offset and clamp limits at accumulator width
    localparam logic signed [ACC_W-1:0] ROUND_HALF = 1 << (biquad_pkg::COEF_FRAC - 1);
    localparam logic signed [ACC_W-1:0] SAT_MAX    = 32767;
    localparam logic signed [ACC_W-1:0] SAT_MIN    = -32768;

    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        TAP_B0 = 4'd1,
        TAP_B1 = 4'd2,
        TAP_B2 = 4'd3,
        TAP_A1 = 4'd4,
        TAP_A2 = 4'd5,
        FINISH = 4'd6,
        HOLD   = 4'd7
    } state_e;

    state_e state;
    state_e next_state;

    // Input and output history
    biquad_pkg::sample_t x_n;
    biquad_pkg::sample_t x_n1;
    biquad_pkg::sample_t x_n2;
    biquad_pkg::sample_t y_n1;
    biquad_pkg::sample_t y_n2;

    // MAC operands and controls
    biquad_pkg::coef_t   mac_coef;
    biquad_pkg::sample_t mac_data;
    logic                mac_en;
    logic                mac_clear;
    logic                mac_negate;
    logic signed [ACC_W-1:0] acc;

    logic signed [ACC_W-1:0] acc_round;
    logic signed [ACC_W-1:0] acc_shift;
    biquad_pkg::sample_t     sat_value;
    logic                    out_fire;

    assign in_ready     = (state == IDLE);
    assign sample_start = in_valid && in_ready;
    assign out_fire     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (sample_start) next_state = TAP_B0;
            TAP_B0:  next_state = TAP_B1;
            TAP_B1:  next_state = TAP_B2;
            TAP_B2:  next_state = TAP_A1;
            TAP_A1:  next_state = TAP_A2;
            TAP_A2:  next_state = FINISH;
            FINISH:  next_state = HOLD;
            HOLD:    if (out_fire) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // x history shifts on accept, y history on output transfer
    always_ff @(posedge clk) begin
        if (!reset) begin
            x_n  <= '0;
            x_n1 <= '0;
            x_n2 <= '0;
            y_n1 <= '0;
            y_n2 <= '0;
        end else begin
            if (sample_start) begin
                x_n  <= in_sample;
                x_n1 <= x_n;
                x_n2 <= x_n1;
            end
            if (out_fire) begin
                y_n1 <= out_sample;
                y_n2 <= y_n1;
            end
        end
    end

    // One tap per cycle through the shared MAC
    always_comb begin
        mac_en     = 1'b1;
        mac_clear  = 1'b0;
        mac_negate = 1'b0;
        mac_coef   = '0;
        mac_data   = '0;
        case (state)
            TAP_B0: begin
                mac_clear = 1'b1;   // Drops the previous sample's sum
                mac_coef  = coefs.b0;
                mac_data  = x_n;
            end
            TAP_B1: begin
                mac_coef = coefs.b1;
                mac_data = x_n1;
            end
            TAP_B2: begin
                mac_coef = coefs.b2;
                mac_data = x_n2;
            end
            TAP_A1: begin
                mac_negate = 1'b1;
                mac_coef   = coefs.a1;
                mac_data   = y_n1;
            end
            TAP_A2: begin
                mac_negate = 1'b1;
                mac_coef   = coefs.a2;
                mac_data   = y_n2;
            end
            default: mac_en = 1'b0;
        endcase
    end

    // Round half up, back to integer, clamp to 16 bits
    always_comb begin
        acc_round = acc + ROUND_HALF;
        acc_shift = acc_round >>> biquad_pkg::COEF_FRAC;
        if (acc_shift > SAT_MAX) begin
            sat_value = 16'sh7fff;
        end else if (acc_shift < SAT_MIN) begin
            sat_value = 16'sh8000;
        end else begin
            sat_value = acc_shift[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (state == FINISH) begin
            out_valid <= 1'b1;
        end else if (out_fire) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FINISH) out_sample <= sat_value;   // Held through HOLD
    end

    mac_accum #(
        .ACC_W (ACC_W)
    ) u_mac (
        .clk    (clk),
        .reset  (reset),
        .clear  (mac_clear),
        .enable (mac_en),
        .a_in   (mac_coef),
        .b_in   (mac_data),
        .negate (mac_negate),
        .acc    (acc)
    );

    a_out_stable: assert property (
        @(posedge clk) disable iff (!reset)
        out_valid && !out_ready |=> out_valid && $stable(out_sample)
    ) else $error("biquad_sequencer: output changed while stalled");

    // No new sample while a result is pending
    a_no_accept_while_valid: assert property (
        @(posedge clk) disable iff (!reset)
        !(in_ready && out_valid)
    ) else $error("biquad_sequencer: in_ready high with out_valid");

    a_state_legal: assert property (
        @(posedge clk) disable iff (!reset)
        state inside {IDLE, TAP_B0, TAP_B1, TAP_B2, TAP_A1, TAP_A2, FINISH, HOLD}
    ) else $error("biquad_sequencer: illegal state");

endmodule

//--- hw/iir_filter_top.sv
// Biquad IIR filter top
`timescale 1ns/1ps

module iir_filter_top #(
    parameter int ACC_W = 36
) (
    input  logic                 clk,
    input  logic                 reset,

    // Sample in
    input  logic                 in_valid,
    output logic                 in_ready,
    input  biquad_pkg::sample_t  in_sample,

    // Sample out
    output logic                 out_valid,
    input  logic                 out_ready,
    output biquad_pkg::sample_t  out_sample,

    // Coefficient port
    input  logic                 coef_wr_en,
    input  biquad_pkg::coef_wr_t coef_wr,
    input  logic                 coef_commit
);

    biquad_pkg::coef_set_t coefs;
    logic                  sample_start;   // Accept edge, also the commit point

    coef_bank u_coef_bank (
        .clk          (clk),
        .reset        (reset),
        .coef_wr_en   (coef_wr_en),
        .coef_wr      (coef_wr),
        .coef_commit  (coef_commit),
        .sample_start (sample_start),
        .coefs        (coefs)
    );

    // Eight cycles per sample minimum, one sample in flight
    biquad_sequencer #(
        .ACC_W (ACC_W)
    ) u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_sample    (in_sample),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_sample   (out_sample),
        .coefs        (coefs),
        .sample_start (sample_start)
    );

endmodule

//--- sim/tb_iir_filter.sv
// Biquad IIR filter testbench
`timescale 1ns/1ps

module tb_iir_filter;

    localparam int CLK_PERIOD   = 20;
    localparam logic [31:0] LFSR_SEED = 32'hb4979f5f;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;
    localparam int N_RESET      = 6;
    localparam int N_RANDOM     = 40;
    localparam int N_SAT        = 16;
    localparam int N_BP         = 40;
    localparam int N_COMMIT     = 10;   // Per half of the commit test
    localparam int NUM_SAMPLES  = N_RESET + N_RANDOM + N_SAT + N_BP + 2 * N_COMMIT;
    localparam int MARGIN       = 4;
    localparam int GAP_BUDGET   = 3 * N_BP + 300;   // Valid gaps, coef writes, reset, drains
    localparam int WATCHDOG_CYCLES = NUM_SAMPLES * 8 * MARGIN + GAP_BUDGET;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    biquad_pkg::sample_t   in_sample;
    logic                  out_valid;
    logic                  out_ready;
    biquad_pkg::sample_t   out_sample;
    logic                  coef_wr_en;
    biquad_pkg::coef_wr_t  coef_wr;
    logic                  coef_commit;

    logic [31:0]           rng_state;
    logic                  ready_random;
    int                    error_count;
    int                    test_errors_start;
    int                    tests_failed;
    int                    accept_count;
    int                    out_count;
    int                    sat_count;

    // Reference model state
    biquad_pkg::coef_set_t m_shadow;
    biquad_pkg::coef_set_t m_active;
    logic                  m_pending;
    logic                  m_swap;
    longint                m_x1;
    longint                m_x2;
    longint                m_y1;
    longint                m_y2;
    biquad_pkg::sample_t   exp_q[$];
    logic                  stall_prev;
    biquad_pkg::sample_t   held_sample;

    iir_filter_top #(
        .ACC_W (36)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_sample   (in_sample),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_sample  (out_sample),
        .coef_wr_en  (coef_wr_en),
        .coef_wr     (coef_wr),
        .coef_commit (coef_commit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], rng_state[0]};
            rng_state = rng_state[0] ? ((rng_state >> 1) ^ LFSR_POLY) : (rng_state >> 1);
        end
        return bits;
    endfunction

    function automatic biquad_pkg::coef_t rand_coef(input int width);
        logic [31:0] raw;
        raw = take_bits(width);
        return biquad_pkg::coef_t'(int'(raw) - (1 << (width - 1)));   // Centered on zero
    endfunction

    function automatic biquad_pkg::sample_t rand_sample();
        logic [31:0] raw;
        raw = take_bits(16);
        return biquad_pkg::sample_t'(raw[15:0]);
    endfunction

    // Direct form I with round half up and clamp
    function automatic biquad_pkg::sample_t model_filter(input longint x);
        longint sum;
        longint res;
        sum = longint'(m_active.b0) * x + longint'(m_active.b1) * m_x1
            + longint'(m_active.b2) * m_x2 - longint'(m_active.a1) * m_y1
            - longint'(m_active.a2) * m_y2;
        res = (sum + (longint'(1) <<< (biquad_pkg::COEF_FRAC - 1))) >>> biquad_pkg::COEF_FRAC;
        if (res > 32767) res = 32767;
        if (res < -32768) res = -32768;
        return biquad_pkg::sample_t'(res);
    endfunction

    task automatic model_accept(input biquad_pkg::sample_t x);
        biquad_pkg::sample_t y;
        y = model_filter(longint'(x));
        exp_q.push_back(y);
        m_x2 = m_x1;
        m_x1 = x;
        m_y2 = m_y1;
        m_y1 = y;   // One sample in flight, so own output is the feedback
    endtask

    task automatic check_output(input biquad_pkg::sample_t got);
        biquad_pkg::sample_t expected;
        if (exp_q.size() == 0) begin
            $display("Output %h appeared with no sample pending", got);
            error_count++;
        end else begin
            expected = exp_q.pop_front();
            if (got !== expected) begin
                $display("CHECK FAILED out_sample expected %h got %h", expected, got);
                error_count++;
            end
        end
        if (got == 16'sh7fff || got == 16'sh8000) sat_count++;   // DUT output at a clamp
        out_count++;
    endtask

    // Monitor, bank model and handshake rules
    always @(posedge clk) begin
        if (!reset) begin
            m_shadow   = '{b0: 16'sd16384, b1: '0, b2: '0, a1: '0, a2: '0};
            m_active   = m_shadow;
            m_pending  = 1'b0;
            m_x1 = 0;
            m_x2 = 0;
            m_y1 = 0;
            m_y2 = 0;
            stall_prev = 1'b0;
        end else begin
            if (in_ready && out_valid) begin
                $display("in_ready was high while an output was pending");
                error_count++;
            end
            if (stall_prev) begin
                if (!out_valid) begin
                    $display("Output was dropped while out_ready was low");
                    error_count++;
                end else if (out_sample !== held_sample) begin
                    $display("CHECK FAILED out_sample expected %h got %h", held_sample,
                             out_sample);
                    error_count++;
                end
            end
            if (out_valid && out_ready) check_output(out_sample);
            stall_prev  = out_valid && !out_ready;
            held_sample = out_sample;

            m_swap = in_valid && in_ready && m_pending;
            if (m_swap) m_active = m_shadow;   // Old shadow, same edge as the accept
            if (in_valid && in_ready) begin
                model_accept(in_sample);
                accept_count++;
            end
            if (coef_wr_en) begin
                case (coef_wr.sel)
                    biquad_pkg::B0: m_shadow.b0 = coef_wr.value;
                    biquad_pkg::B1: m_shadow.b1 = coef_wr.value;
                    biquad_pkg::B2: m_shadow.b2 = coef_wr.value;
                    biquad_pkg::A1: m_shadow.a1 = coef_wr.value;
                    biquad_pkg::A2: m_shadow.a2 = coef_wr.value;
                    default: ;
                endcase
            end
            if (coef_commit) m_pending = 1'b1;
            else if (m_swap) m_pending = 1'b0;
        end
    end

    // Every wait goes through here so out_ready moves each cycle
    task automatic next_cycle();
        @(negedge clk);
        if (ready_random) out_ready = (take_bits(2) != 0);
        else out_ready = 1'b1;
    endtask

    task automatic write_coef(input biquad_pkg::coef_sel_e sel, input biquad_pkg::coef_t value);
        coef_wr_en    = 1'b1;
        coef_wr.sel   = sel;
        coef_wr.value = value;
        next_cycle();
        coef_wr_en = 1'b0;
    endtask

    task automatic load_coefs(input biquad_pkg::coef_set_t set, input logic commit);
        write_coef(biquad_pkg::B0, set.b0);
        write_coef(biquad_pkg::B1, set.b1);
        write_coef(biquad_pkg::B2, set.b2);
        write_coef(biquad_pkg::A1, set.a1);
        write_coef(biquad_pkg::A2, set.a2);
        if (commit) begin
            coef_commit = 1'b1;
            next_cycle();
            coef_commit = 1'b0;
        end
    endtask

    function automatic biquad_pkg::coef_set_t moderate_set();
        biquad_pkg::coef_set_t set;
        set.b0 = rand_coef(14);   // About +-0.5
        set.b1 = rand_coef(14);
        set.b2 = rand_coef(14);
        set.a1 = rand_coef(14);
        set.a2 = rand_coef(13);
        return set;
    endfunction

    task automatic send_sample(input biquad_pkg::sample_t value, input int gap);
        int start;
        int waited;
        repeat (gap) next_cycle();
        start     = accept_count;
        waited    = 0;
        in_valid  = 1'b1;
        in_sample = value;
        while (accept_count == start && waited < 64) begin
            next_cycle();
            waited++;
        end
        if (accept_count == start) begin
            $display("Sample %h was not accepted, in_ready stayed low", value);
            error_count++;
        end
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || out_valid) && waited < 100) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_q.size());
            error_count++;
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors_start) begin
            $display("test %0s: pass", name);
        end else begin
            $display("test %0s: FAIL with %0d errors", name, error_count - test_errors_start);
            tests_failed++;
        end
        test_errors_start = error_count;
    endtask

    initial begin
        biquad_pkg::coef_set_t set;
        biquad_pkg::sample_t   x;
        int                    sat_start;
        clk = 1'b0;
        reset = 1'b0;
        in_valid = 1'b0;
        in_sample = '0;
        out_ready = 1'b0;
        coef_wr_en = 1'b0;
        coef_wr = '0;
        coef_commit = 1'b0;
        rng_state = LFSR_SEED;
        ready_random = 1'b0;
        error_count = 0;
        test_errors_start = 0;
        tests_failed = 0;
        accept_count = 0;
        out_count = 0;
        sat_count = 0;
        repeat (8) next_cycle();
        reset = 1'b1;
        next_cycle();

        // Defaults make a passthrough
        if (in_ready !== 1'b1) begin
            $display("CHECK FAILED in_ready expected %h got %h", 1'b1, in_ready);
            error_count++;
        end
        if (out_valid !== 1'b0) begin
            $display("CHECK FAILED out_valid expected %h got %h", 1'b0, out_valid);
            error_count++;
        end
        for (int i = 0; i < N_RESET; i++) send_sample(rand_sample(), 0);
        drain_outputs();
        end_test("reset_passthrough");

        load_coefs(moderate_set(), 1'b1);
        for (int i = 0; i < N_RANDOM; i++) send_sample(rand_sample(), 0);
        drain_outputs();
        end_test("random_filtering");

        set = '{b0: 16'sd32604, b1: '0, b2: '0, a1: -16'sd8192, a2: '0};   // 1.99 gain
        load_coefs(set, 1'b1);
        sat_start = sat_count;
        for (int i = 0; i < N_SAT; i++) begin
            x = biquad_pkg::sample_t'(30000 + int'(take_bits(11)));
            if (take_bits(1) != 0) x = -x;
            send_sample(x, 0);
        end
        drain_outputs();
        if (sat_count == sat_start) begin
            $display("No output reached a clamp limit in the saturation run");
            error_count++;
        end
        end_test("saturation");

        load_coefs(moderate_set(), 1'b1);
        ready_random = 1'b1;
        for (int i = 0; i < N_BP; i++) send_sample(rand_sample(), int'(take_bits(2)));
        drain_outputs();
        ready_random = 1'b0;
        end_test("back_pressure");

        // Shadow only, then commit mid-stream
        load_coefs(moderate_set(), 1'b0);
        for (int i = 0; i < N_COMMIT; i++) send_sample(rand_sample(), 0);
        coef_commit = 1'b1;
        next_cycle();
        coef_commit = 1'b0;
        for (int i = 0; i < N_COMMIT; i++) send_sample(rand_sample(), 0);
        drain_outputs();
        end_test("commit_boundary");

        $display("Summary: 5 tests, %0d failed, %0d errors, %0d outputs checked",
                 tests_failed, error_count, out_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- iir_biquad.f
hw/biquad_pkg.sv
hw/mac_accum.sv
hw/coef_bank.sv
hw/biquad_sequencer.sv
hw/iir_filter_top.sv
sim/tb_iir_filter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the biquad IIR testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_iir_filter
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f iir_biquad.f -o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation passed"
